// File: src/gem_csc_pkg.sv
////////////////////////////////////////
// GEM/CSC ME1/1 geometry: field widths, region limits
// and the pad/roll table formulas behind the LUT ROMs
////////////////////////////////////////
`default_nettype none

package gem_csc_pkg;

   localparam int XKY_BITS     = 10;  // eighth-strip key
   localparam int WIRE_BITS    = 7;   // wiregroup
   localparam int PAD_BITS     = 8;
   localparam int ROLL_BITS    = 3;
   localparam int SIZE_BITS    = 3;   // 0 means a single pad
   localparam int CLUSTER_BITS = 14;  // raw cluster word

   localparam int ME1B_XKY_MIN = 0;
   localparam int ME1B_XKY_MAX = 511;
   localparam int ME1A_XKY_MIN = 512;
   localparam int ME1A_XKY_MAX = 895;

   localparam int LAST_PAD  = 191;    // pads beyond this alias to it
   localparam int ME1A_ROLL = 7;      // eta above 2.1

   // me1b keys spread 192 pads over 512 eighth strips
   function automatic logic [XKY_BITS-1:0] me1b_xky_of(input int pad, input logic even);
      return even ? XKY_BITS'(pad * 8 / 3) : XKY_BITS'(ME1B_XKY_MAX - pad * 8 / 3);
   endfunction

   function automatic logic [XKY_BITS-1:0] me1a_xky_of(input int pad, input logic even);
      return even ? XKY_BITS'(ME1A_XKY_MIN + pad * 2) : XKY_BITS'(ME1A_XKY_MAX - pad * 2);
   endfunction

   // odd chambers are mirrored, so lo/hi come out swapped
   function automatic logic [WIRE_BITS-1:0] wg_lo_of(input int roll, input logic even);
      return even ? WIRE_BITS'(roll * 6) : WIRE_BITS'(47 - roll * 6);
   endfunction

   function automatic logic [WIRE_BITS-1:0] wg_hi_of(input int roll, input logic even);
      return even ? WIRE_BITS'(roll * 6 + 5) : WIRE_BITS'(47 - (roll * 6 + 5));
   endfunction

endpackage

`default_nettype wire

// File: src/gem_csc_cfg_pkg.sv
////////////////////////////////////////
// match configuration: opcodes, control states, defaults
////////////////////////////////////////
`default_nettype none

package gem_csc_cfg_pkg;

   typedef enum logic [1:0] {
      OP_SET_HS_WINDOW = 2'd0,  // data[4:0]
      OP_SET_WG_WINDOW = 2'd1,  // data[2:0]
      OP_SET_ENABLES   = 2'd2,  // data[0] match, [1] me1a, [2] me1b
      OP_SET_PARITY    = 2'd3   // data[0] even chamber
   } cfg_op_e;

   typedef enum logic {
      ST_RUN   = 1'b0,
      ST_FLUSH = 1'b1
   } ctrl_state_e;

   localparam int HS_WIN_BITS = 5;
   localparam int WG_WIN_BITS = 3;

   localparam logic [HS_WIN_BITS-1:0] HS_WINDOW_DEF    = '0;
   localparam logic [WG_WIN_BITS-1:0] WG_WINDOW_DEF    = '0;
   localparam logic [2:0]             ENABLES_DEF      = 3'b111;  // me1b, me1a, match
   localparam logic                   EVEN_CHAMBER_DEF = 1'b1;

   localparam int PIPE_DEPTH = 2;  // cycles of results in flight

endpackage

`default_nettype wire

// File: src/gem_csc_ifs.sv
////////////////////////////////////////
// cluster and match configuration interfaces
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface cluster_if;
   import gem_csc_pkg::*;

   logic [CLUSTER_BITS-1:0] cluster;
   logic                    vpf;     // cluster valid
   logic [ROLL_BITS-1:0]    roll;
   logic [PAD_BITS-1:0]     pad;
   logic [SIZE_BITS-1:0]    size;

   modport src (output cluster, vpf, roll, pad, size);
   modport dst (input  cluster, vpf, roll, pad, size);
endinterface

interface match_cfg_if;
   import gem_csc_cfg_pkg::*;

   logic [HS_WIN_BITS-1:0] hs_window;  // half strips
   logic [WG_WIN_BITS-1:0] wg_window;  // wiregroups
   logic match_en, me1a_en, me1b_en;
   logic even_chamber;
   logic flushing;                     // parity change in progress

   modport ctrl (output hs_window, wg_window, match_en, me1a_en, me1b_en, even_chamber, flushing);
   modport dp   (input  hs_window, wg_window, match_en, me1a_en, me1b_en, even_chamber, flushing);
endinterface

`default_nettype wire

// File: src/gem_pad_xky_lut.sv
////////////////////////////////////////
// GEM pad to CSC eighth-strip ROM, two reads per cycle
// ME1a/ME1b banks, each with even and odd chamber tables
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module gem_pad_xky_lut (
   input  wire logic                             logic_clock,
   match_cfg_if.dp                               cfg,
   input  wire logic [gem_csc_pkg::PAD_BITS-1:0] adr_lo,
   input  wire logic [gem_csc_pkg::PAD_BITS-1:0] adr_hi,
   output logic      [gem_csc_pkg::XKY_BITS-1:0] me1a_lo,
   output logic      [gem_csc_pkg::XKY_BITS-1:0] me1a_hi,
   output logic      [gem_csc_pkg::XKY_BITS-1:0] me1b_lo,
   output logic      [gem_csc_pkg::XKY_BITS-1:0] me1b_hi
);
   import gem_csc_pkg::*;

   localparam int DEPTH = 2 ** PAD_BITS;

   logic [XKY_BITS-1:0] me1a_even [DEPTH];
   logic [XKY_BITS-1:0] me1a_odd  [DEPTH];
   logic [XKY_BITS-1:0] me1b_even [DEPTH];
   logic [XKY_BITS-1:0] me1b_odd  [DEPTH];

   // rom contents, read-only after configuration
   initial begin
      int p;
      for (int i = 0; i < DEPTH; i++) begin
         p = (i > LAST_PAD) ? LAST_PAD : i;  // padding entries repeat the last pad
         me1a_even[i] = me1a_xky_of(p, 1'b1);
         me1a_odd[i]  = me1a_xky_of(p, 1'b0);
         me1b_even[i] = me1b_xky_of(p, 1'b1);
         me1b_odd[i]  = me1b_xky_of(p, 1'b0);
      end
   end

   // registered reads, bank chosen by chamber parity
   always_ff @(posedge logic_clock) begin
      if (cfg.even_chamber) begin
         me1a_lo <= me1a_even[adr_lo];
         me1a_hi <= me1a_even[adr_hi];
         me1b_lo <= me1b_even[adr_lo];
         me1b_hi <= me1b_even[adr_hi];
      end else begin
         me1a_lo <= me1a_odd[adr_lo];   // mirrored, lo > hi
         me1a_hi <= me1a_odd[adr_hi];
         me1b_lo <= me1b_odd[adr_lo];
         me1b_hi <= me1b_odd[adr_hi];
      end
   end

endmodule

`default_nettype wire

// File: src/gem_roll_wg_lut.sv
////////////////////////////////////////
// GEM roll to CSC wiregroup span ROM
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module gem_roll_wg_lut (
   input  wire logic                              logic_clock,
   match_cfg_if.dp                                cfg,
   input  wire logic [gem_csc_pkg::ROLL_BITS-1:0] roll,
   output logic      [gem_csc_pkg::WIRE_BITS-1:0] wg_lo,
   output logic      [gem_csc_pkg::WIRE_BITS-1:0] wg_hi
);
   import gem_csc_pkg::*;

   localparam int DEPTH = 2 ** ROLL_BITS;

   logic [WIRE_BITS-1:0] lo_even [DEPTH];
   logic [WIRE_BITS-1:0] hi_even [DEPTH];
   logic [WIRE_BITS-1:0] lo_odd  [DEPTH];
   logic [WIRE_BITS-1:0] hi_odd  [DEPTH];

   initial begin
      for (int r = 0; r < DEPTH; r++) begin
         lo_even[r] = wg_lo_of(r, 1'b1);
         hi_even[r] = wg_hi_of(r, 1'b1);
         lo_odd[r]  = wg_lo_of(r, 1'b0);  // odd chamber counts down
         hi_odd[r]  = wg_hi_of(r, 1'b0);
      end
   end

   always_ff @(posedge logic_clock) begin
      wg_lo <= cfg.even_chamber ? lo_even[roll] : lo_odd[roll];
      wg_hi <= cfg.even_chamber ? hi_even[roll] : hi_odd[roll];
   end

endmodule

`default_nettype wire

// File: src/cluster_match_ctrl.sv
////////////////////////////////////////
// match configuration registers and parity flush FSM
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cluster_match_ctrl (
   input  wire logic                      logic_clock,
   input  wire logic                      rst_n,
   input  wire logic                      cfg_wr,    // one-cycle write strobe
   input  wire gem_csc_cfg_pkg::cfg_op_e  cfg_op,
   input  wire logic [7:0]                cfg_data,
   match_cfg_if.ctrl                      cfg
);
   import gem_csc_cfg_pkg::*;

   localparam int CNT_BITS = $clog2(PIPE_DEPTH + 1);

   ctrl_state_e         state;
   logic [CNT_BITS-1:0] flush_cnt;  // cycles left in flush
   logic                parity_wr;

   // a parity write only matters if it flips the chamber type
   assign parity_wr = cfg_wr && (cfg_op == OP_SET_PARITY) &&
                      (cfg_data[0] != cfg.even_chamber);

   // config registers, new values seen the cycle after the strobe
   always_ff @(posedge logic_clock or negedge rst_n) begin
      if (!rst_n) begin
         cfg.hs_window    <= HS_WINDOW_DEF;
         cfg.wg_window    <= WG_WINDOW_DEF;
         cfg.match_en     <= ENABLES_DEF[0];
         cfg.me1a_en      <= ENABLES_DEF[1];
         cfg.me1b_en      <= ENABLES_DEF[2];
         cfg.even_chamber <= EVEN_CHAMBER_DEF;
      end else if (cfg_wr) begin
         case (cfg_op)
            OP_SET_HS_WINDOW: cfg.hs_window <= cfg_data[HS_WIN_BITS-1:0];
            OP_SET_WG_WINDOW: cfg.wg_window <= cfg_data[WG_WIN_BITS-1:0];
            OP_SET_ENABLES: begin
               cfg.match_en <= cfg_data[0];
               cfg.me1a_en  <= cfg_data[1];
               cfg.me1b_en  <= cfg_data[2];
            end
            OP_SET_PARITY:    cfg.even_chamber <= cfg_data[0];
            default: ;
         endcase
      end
   end

   // flush covers the clusters read with the old tables
   always_ff @(posedge logic_clock or negedge rst_n) begin
      if (!rst_n) begin
         state     <= ST_RUN;
         flush_cnt <= '0;
      end else if (parity_wr) begin   // restarts if already flushing
         state     <= ST_FLUSH;
         flush_cnt <= CNT_BITS'(PIPE_DEPTH - 1);
      end else begin
         case (state)
            ST_FLUSH: begin
               if (flush_cnt == '0) state <= ST_RUN;
               else flush_cnt <= flush_cnt - 1'b1;
            end
            default: state <= ST_RUN;
         endcase
      end
   end

   assign cfg.flushing = (state == ST_FLUSH);

endmodule

`default_nettype wire

// File: src/cluster_window_calc.sv
////////////////////////////////////////
// lo/hi ordering, window widening, clamping and midpoints
// region select, valid gating and the output register
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cluster_window_calc #(
   parameter int MAX_WIRE = 47  // last wiregroup of the chamber
) (
   input  wire logic                                 logic_clock,
   input  wire logic                                 rst_n,
   match_cfg_if.dp                                   cfg,
   cluster_if.dst                                    clu,
   input  wire logic [gem_csc_pkg::XKY_BITS-1:0]     me1a_lo,
   input  wire logic [gem_csc_pkg::XKY_BITS-1:0]     me1a_hi,
   input  wire logic [gem_csc_pkg::XKY_BITS-1:0]     me1b_lo,
   input  wire logic [gem_csc_pkg::XKY_BITS-1:0]     me1b_hi,
   input  wire logic [gem_csc_pkg::WIRE_BITS-1:0]    wg_lo,
   input  wire logic [gem_csc_pkg::WIRE_BITS-1:0]    wg_hi,
   output logic      [gem_csc_pkg::WIRE_BITS-1:0]    out_wire_lo,
   output logic      [gem_csc_pkg::WIRE_BITS-1:0]    out_wire_hi,
   output logic      [gem_csc_pkg::WIRE_BITS-1:0]    out_wire_mi,
   output logic      [gem_csc_pkg::XKY_BITS-1:0]     out_xky_lo,
   output logic      [gem_csc_pkg::XKY_BITS-1:0]     out_xky_hi,
   output logic      [gem_csc_pkg::XKY_BITS-1:0]     out_xky_mi,
   output logic                                      out_me1a,
   output logic      [gem_csc_pkg::CLUSTER_BITS-1:0] out_cluster,
   output logic                                      out_vpf,
   output logic      [gem_csc_pkg::ROLL_BITS-1:0]    out_roll,
   output logic      [gem_csc_pkg::PAD_BITS-1:0]     out_pad,
   output logic      [gem_csc_pkg::SIZE_BITS-1:0]    out_size
);
   import gem_csc_pkg::*;

   logic                 is_me1a, vld;
   logic [XKY_BITS-1:0]  xky_a, xky_b, xky_min, xky_max, lim_lo, lim_hi;
   logic [XKY_BITS-1:0]  xky_lo_w, xky_hi_w, xky_mi;
   logic [XKY_BITS:0]    delta_xky, xky_hi_sum;   // one spare bit for overflow
   logic [WIRE_BITS-1:0] wg_min, wg_max, wg_lo_w, wg_hi_w, wg_mi;
   logic [WIRE_BITS:0]   delta_wg, wg_hi_sum;

   // rounds up when either end is odd
   function automatic logic [XKY_BITS-1:0] midpoint(input logic [XKY_BITS-1:0] a,
                                                    input logic [XKY_BITS-1:0] b);
      return (a >> 1) + (b >> 1) + XKY_BITS'(a[0] | b[0]);
   endfunction

   assign is_me1a = (clu.roll == ROLL_BITS'(ME1A_ROLL)) && cfg.me1a_en;  // else me1b

   assign xky_a   = is_me1a ? me1a_lo : me1b_lo;
   assign xky_b   = is_me1a ? me1a_hi : me1b_hi;
   assign xky_min = (xky_a < xky_b) ? xky_a : xky_b;  // odd tables arrive swapped
   assign xky_max = (xky_a < xky_b) ? xky_b : xky_a;
   assign lim_lo  = is_me1a ? XKY_BITS'(ME1A_XKY_MIN) : XKY_BITS'(ME1B_XKY_MIN);
   assign lim_hi  = is_me1a ? XKY_BITS'(ME1A_XKY_MAX) : XKY_BITS'(ME1B_XKY_MAX);

   // half strip window in eighth strips
   assign delta_xky  = (XKY_BITS + 1)'({cfg.hs_window, 2'b00});
   assign xky_lo_w   = ({1'b0, xky_min} >= {1'b0, lim_lo} + delta_xky) ?
                       XKY_BITS'({1'b0, xky_min} - delta_xky) : lim_lo;
   assign xky_hi_sum = {1'b0, xky_max} + delta_xky;
   assign xky_hi_w   = (xky_hi_sum > {1'b0, lim_hi}) ? lim_hi : xky_hi_sum[XKY_BITS-1:0];
   assign xky_mi     = midpoint(xky_min, xky_max);  // before widening

   assign wg_min    = (wg_lo < wg_hi) ? wg_lo : wg_hi;
   assign wg_max    = (wg_lo < wg_hi) ? wg_hi : wg_lo;
   assign delta_wg  = (WIRE_BITS + 1)'(cfg.wg_window);
   assign wg_lo_w   = ({1'b0, wg_min} > delta_wg) ? WIRE_BITS'({1'b0, wg_min} - delta_wg) : '0;
   assign wg_hi_sum = {1'b0, wg_max} + delta_wg;
   assign wg_hi_w   = (wg_hi_sum > (WIRE_BITS + 1)'(MAX_WIRE)) ?
                      WIRE_BITS'(MAX_WIRE) : wg_hi_sum[WIRE_BITS-1:0];
   assign wg_mi     = WIRE_BITS'(midpoint(XKY_BITS'(wg_min), XKY_BITS'(wg_max)));

   assign vld = clu.vpf && cfg.match_en && (cfg.me1b_en || is_me1a) && !cfg.flushing;

   always_ff @(posedge logic_clock or negedge rst_n) begin
      if (!rst_n) out_vpf <= 1'b0;
      else        out_vpf <= vld;
   end

   // payload, only qualified by out_vpf
   always_ff @(posedge logic_clock) begin
      out_wire_lo <= wg_lo_w;
      out_wire_hi <= wg_hi_w;
      out_wire_mi <= wg_mi;
      out_xky_lo  <= xky_lo_w;
      out_xky_hi  <= xky_hi_w;
      out_xky_mi  <= xky_mi;
      out_me1a    <= is_me1a;
      out_cluster <= clu.cluster;
      out_roll    <= clu.roll;
      out_pad     <= clu.pad;
      out_size    <= clu.size;
   end

endmodule

`default_nettype wire

// File: src/cluster_to_csc_top.sv
////////////////////////////////////////
// GEM cluster to CSC wiregroup/eighth-strip translation
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cluster_to_csc_top #(
   parameter int MAX_WIRE = 47
) (
   input  wire logic                                 logic_clock,
   input  wire logic                                 rst_n,
   input  wire logic                                 cfg_wr,
   input  wire gem_csc_cfg_pkg::cfg_op_e             cfg_op,
   input  wire logic [7:0]                           cfg_data,
   input  wire logic [gem_csc_pkg::CLUSTER_BITS-1:0] in_cluster,
   input  wire logic                                 in_vpf,
   input  wire logic [gem_csc_pkg::ROLL_BITS-1:0]    in_roll,
   input  wire logic [gem_csc_pkg::PAD_BITS-1:0]     in_pad,
   input  wire logic [gem_csc_pkg::SIZE_BITS-1:0]    in_size,
   output logic      [gem_csc_pkg::WIRE_BITS-1:0]    out_wire_lo,
   output logic      [gem_csc_pkg::WIRE_BITS-1:0]    out_wire_hi,
   output logic      [gem_csc_pkg::WIRE_BITS-1:0]    out_wire_mi,
   output logic      [gem_csc_pkg::XKY_BITS-1:0]     out_xky_lo,
   output logic      [gem_csc_pkg::XKY_BITS-1:0]     out_xky_hi,
   output logic      [gem_csc_pkg::XKY_BITS-1:0]     out_xky_mi,
   output logic                                      out_me1a,
   output logic      [gem_csc_pkg::CLUSTER_BITS-1:0] out_cluster,
   output logic                                      out_vpf,
   output logic      [gem_csc_pkg::ROLL_BITS-1:0]    out_roll,
   output logic      [gem_csc_pkg::PAD_BITS-1:0]     out_pad,
   output logic      [gem_csc_pkg::SIZE_BITS-1:0]    out_size
);
   import gem_csc_pkg::*;

   cluster_if   clu();
   match_cfg_if cfg();

   logic [PAD_BITS-1:0]  adr_lo, adr_hi;
   logic [ROLL_BITS-1:0] adr_roll;
   logic [XKY_BITS-1:0]  me1a_lo, me1a_hi, me1b_lo, me1b_hi;
   logic [WIRE_BITS-1:0] wg_lo, wg_hi;

   // idle cycles read address 0
   assign adr_lo   = in_vpf ? in_pad : '0;
   assign adr_hi   = in_vpf ? in_pad + PAD_BITS'(in_size) : '0;  // last pad of cluster
   assign adr_roll = in_vpf ? in_roll : '0;

   // staging, lines the cluster up with the rom data
   always_ff @(posedge logic_clock or negedge rst_n) begin
      if (!rst_n) clu.vpf <= 1'b0;
      else        clu.vpf <= in_vpf;
   end

   always_ff @(posedge logic_clock) begin
      clu.cluster <= in_cluster;
      clu.roll    <= in_roll;
      clu.pad     <= in_pad;
      clu.size    <= in_size;
   end

   cluster_match_ctrl i_ctrl (
      .logic_clock, .rst_n, .cfg_wr, .cfg_op, .cfg_data, .cfg(cfg.ctrl)
   );

   gem_pad_xky_lut i_pad_lut (
      .logic_clock, .cfg(cfg.dp), .adr_lo, .adr_hi,
      .me1a_lo, .me1a_hi, .me1b_lo, .me1b_hi
   );

   gem_roll_wg_lut i_roll_lut (
      .logic_clock, .cfg(cfg.dp), .roll(adr_roll), .wg_lo, .wg_hi
   );

   cluster_window_calc #(.MAX_WIRE(MAX_WIRE)) i_calc (
      .logic_clock, .rst_n, .cfg(cfg.dp), .clu(clu.dst),
      .me1a_lo, .me1a_hi, .me1b_lo, .me1b_hi, .wg_lo, .wg_hi,
      .out_wire_lo, .out_wire_hi, .out_wire_mi,
      .out_xky_lo, .out_xky_hi, .out_xky_mi, .out_me1a,
      .out_cluster, .out_vpf, .out_roll, .out_pad, .out_size
   );

endmodule

`default_nettype wire

// File: verification/cluster_to_csc_assert.sv
////////////////////////////////////////
// protocol checks bound onto the cluster translation top
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cluster_to_csc_assert (
   input wire logic                              logic_clock,
   input wire logic                              rst_n,
   input wire logic                              out_vpf,
   input wire logic [gem_csc_pkg::WIRE_BITS-1:0] out_wire_lo,
   input wire logic [gem_csc_pkg::WIRE_BITS-1:0] out_wire_hi,
   input wire logic [gem_csc_pkg::XKY_BITS-1:0]  out_xky_lo,
   input wire logic [gem_csc_pkg::XKY_BITS-1:0]  out_xky_hi
);
   import gem_csc_pkg::*;

   int fail_count = 0;  // read by the testbench

   reset_quiet: assert property (@(posedge logic_clock) !rst_n |-> !out_vpf)
      else begin
         fail_count++;
         $error("out_vpf high while in reset");
      end

   wire_order: assert property (@(posedge logic_clock) disable iff (!rst_n)
      out_wire_lo <= out_wire_hi)
      else begin
         fail_count++;
         $error("wiregroup window inverted");
      end

   xky_order: assert property (@(posedge logic_clock) disable iff (!rst_n)
      out_xky_lo <= out_xky_hi)
      else begin
         fail_count++;
         $error("eighth-strip window inverted");
      end

   // keys never leave the chamber, 0 is the unsigned floor
   xky_range: assert property (@(posedge logic_clock) disable iff (!rst_n)
      out_xky_lo <= XKY_BITS'(ME1A_XKY_MAX) && out_xky_hi <= XKY_BITS'(ME1A_XKY_MAX))
      else begin
         fail_count++;
         $error("eighth-strip key beyond the chamber edge");
      end

endmodule

bind cluster_to_csc_top cluster_to_csc_assert i_assert (.*);

`default_nettype wire

// File: verification/tb_cluster_to_csc.sv
////////////////////////////////////////
// testbench for the GEM cluster to CSC translation stage
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_cluster_to_csc;
   import gem_csc_pkg::*;
   import gem_csc_cfg_pkg::*;

   localparam int CLK_PERIOD = 20;
   localparam int MAX_WIRE   = 47;
   localparam int SEED       = 83894;
   localparam int N_BASIC    = 40;  // clusters per parity at default config
   localparam int N_WIN      = 8;   // window settings tried
   localparam int N_RUN      = 20;
   localparam int DRAIN      = 4;
   localparam int TOTAL_CYCLES = 3 + 2 * (N_BASIC + 4) + 1 + N_WIN * (3 + N_RUN + 4)
                                 + 8 * (1 + N_RUN) + 3 * (1 + 4) + DRAIN;

   logic                    logic_clock, rst_n, cfg_wr, in_vpf, out_vpf, out_me1a;
   cfg_op_e                 cfg_op;
   logic [7:0]              cfg_data;
   logic [CLUSTER_BITS-1:0] in_cluster, out_cluster;
   logic [ROLL_BITS-1:0]    in_roll, out_roll;
   logic [PAD_BITS-1:0]     in_pad, out_pad;
   logic [SIZE_BITS-1:0]    in_size, out_size;
   logic [WIRE_BITS-1:0]    out_wire_lo, out_wire_hi, out_wire_mi;
   logic [XKY_BITS-1:0]     out_xky_lo, out_xky_hi, out_xky_mi;

   // reference model with a config copy and two pipeline stages (s_ then e_)
   int                      m_hs, m_wg, m_flush;
   logic [2:0]              m_en;                  // me1b, me1a, match
   logic                    m_even, s_vpf, s_even, s_me1a;
   logic [ROLL_BITS-1:0]    s_roll, e_roll;
   logic [PAD_BITS-1:0]     s_pad, s_plo, s_phi, e_pad;
   logic [SIZE_BITS-1:0]    s_size, e_size;
   logic [CLUSTER_BITS-1:0] s_cluster, e_cluster;
   logic                    e_vpf, e_valid, e_me1a;
   int                      e_wlo, e_whi, e_wmi, e_xlo, e_xhi, e_xmi;

   cluster_to_csc_top #(.MAX_WIRE(MAX_WIRE)) i_dut (.*);

   initial begin
      logic_clock = 1'b0;
      forever #(CLK_PERIOD / 2) logic_clock = ~logic_clock;
   end

   // table formulas with pads past 191 aliased to 191
   function automatic int pad_xky(input int pad, input logic even, input logic me1a);
      int p;
      p = (pad > 191) ? 191 : pad;
      if (me1a) return even ? 512 + 2 * p : 895 - 2 * p;
      return even ? p * 8 / 3 : 511 - p * 8 / 3;
   endfunction

   function automatic int roll_wire(input int roll, input logic even, input logic top);
      int w;
      w = roll * 6 + (top ? 5 : 0);
      return even ? w : 47 - w;  // odd chambers mirrored
   endfunction

   function automatic int half_sum(input int a, input int b);
      return a / 2 + b / 2 + ((a % 2) | (b % 2));
   endfunction

   assign s_me1a = (s_roll == 3'd7) && m_en[1];

   always @(posedge logic_clock or negedge rst_n) begin
      if (!rst_n) begin
         m_hs    <= 0;
         m_wg    <= 0;
         m_en    <= 3'b111;
         m_even  <= 1'b1;
         m_flush <= 0;
         e_vpf   <= 1'b0;
      end else begin
         e_vpf <= s_vpf && m_en[0] && (m_en[2] || s_me1a) && (m_flush == 0);
         if (m_flush != 0) m_flush <= m_flush - 1;
         if (cfg_wr) begin
            case (cfg_op)
               OP_SET_HS_WINDOW: m_hs <= cfg_data[4:0];
               OP_SET_WG_WINDOW: m_wg <= cfg_data[2:0];
               OP_SET_ENABLES:   m_en <= cfg_data[2:0];
               default: begin
                  if (cfg_data[0] != m_even) m_flush <= 2;  // two results in flight
                  m_even <= cfg_data[0];
               end
            endcase
         end
      end
   end

   always @(posedge logic_clock) begin
      int xa, xb, xlo, xhi, wa, wb, wlo, whi, lim;
      s_vpf     <= in_vpf;
      s_even    <= m_even;                      // tables read with the old parity
      s_plo     <= in_pad;
      s_phi     <= in_pad + PAD_BITS'(in_size);  // wraps like the address
      s_pad     <= in_pad;
      s_roll    <= in_roll;
      s_size    <= in_size;
      s_cluster <= in_cluster;
      xa  = pad_xky(s_plo, s_even, s_me1a);
      xb  = pad_xky(s_phi, s_even, s_me1a);
      xlo = (xa < xb) ? xa : xb;
      xhi = (xa < xb) ? xb : xa;
      wa  = roll_wire(s_roll, s_even, 1'b0);
      wb  = roll_wire(s_roll, s_even, 1'b1);
      wlo = (wa < wb) ? wa : wb;
      whi = (wa < wb) ? wb : wa;
      lim = s_me1a ? 512 : 0;
      e_xlo <= (xlo - 4 * m_hs < lim) ? lim : xlo - 4 * m_hs;
      lim = s_me1a ? 895 : 511;
      e_xhi <= (xhi + 4 * m_hs > lim) ? lim : xhi + 4 * m_hs;
      e_xmi <= half_sum(xlo, xhi);              // unwidened
      e_wlo <= (wlo - m_wg < 0) ? 0 : wlo - m_wg;
      e_whi <= (whi + m_wg > MAX_WIRE) ? MAX_WIRE : whi + m_wg;
      e_wmi <= half_sum(wlo, whi);
      e_valid   <= s_vpf;
      e_me1a    <= s_me1a;
      e_cluster <= s_cluster;
      e_roll    <= s_roll;
      e_pad     <= s_pad;
      e_size    <= s_size;
   end

   task automatic mismatch(input string field);
      $display("** Error at %0t: %s does not match the reference", $time, field);
      $display("Simulation finished: FAIL");
      $fatal(1, "output mismatch");
   endtask

   chk_vpf: assert property (@(posedge logic_clock) disable iff (!rst_n) out_vpf == e_vpf)
      else mismatch("out_vpf");
   chk_me1a: assert property (@(posedge logic_clock) disable iff (!rst_n) out_me1a == e_me1a)
      else mismatch("out_me1a");
   chk_wire: assert property (@(posedge logic_clock) disable iff (!rst_n)
      e_valid |-> out_wire_lo == e_wlo && out_wire_hi == e_whi && out_wire_mi == e_wmi)
      else mismatch("out_wire_lo/hi/mi");
   chk_xky: assert property (@(posedge logic_clock) disable iff (!rst_n)
      e_valid |-> out_xky_lo == e_xlo && out_xky_hi == e_xhi && out_xky_mi == e_xmi)
      else mismatch("out_xky_lo/hi/mi");
   chk_pass: assert property (@(posedge logic_clock) disable iff (!rst_n)
      out_cluster == e_cluster && out_roll == e_roll && out_pad == e_pad && out_size == e_size)
      else mismatch("passthrough cluster/roll/pad/size");

   // any bound protocol failure ends the run
   always @(i_dut.i_assert.fail_count) begin
      if (i_dut.i_assert.fail_count != 0) begin
         $display("A bound protocol assertion failed");
         $display("Simulation finished: FAIL");
         $fatal(1, "protocol assertion failed");
      end
   end

   initial begin
      #(2 * TOTAL_CYCLES * CLK_PERIOD);
      $display("Timeout: stimulus still running after %0d cycles", 2 * TOTAL_CYCLES);
      $display("Simulation finished: FAIL");
      $fatal(1, "watchdog expired");
   end

   // one cluster per cycle with inputs changing 2 ns after the edge
   task automatic send(input logic vpf, input int roll, input int pad, input int size);
      in_vpf     = vpf;
      in_roll    = ROLL_BITS'(roll);
      in_pad     = PAD_BITS'(pad);
      in_size    = SIZE_BITS'(size);
      in_cluster = CLUSTER_BITS'($urandom);
      @(posedge logic_clock);
      #2;
      cfg_wr = 1'b0;  // strobe lasts one cycle
   endtask

   task automatic send_random(input logic all_valid);
      send(all_valid || ($urandom_range(7) != 0), $urandom_range(7), $urandom_range(199),
           $urandom_range(7));
   endtask

   task automatic write_cfg(input cfg_op_e op, input logic [7:0] data);
      cfg_wr   = 1'b1;
      cfg_op   = op;
      cfg_data = data;
      send_random(1'b0);
   endtask

   task automatic send_corners;
      send(1'b1, 7, 191, 7);  // top of me1a
      send(1'b1, 0, 191, 7);  // top of me1b
      send(1'b1, 7, 0, 0);
      send(1'b1, 2, 255, 7);  // high address wraps round
   endtask

   initial begin
      void'($urandom(SEED));
      rst_n      = 1'b0;
      cfg_wr     = 1'b0;
      cfg_op     = OP_SET_HS_WINDOW;
      cfg_data   = '0;
      in_vpf     = 1'b0;
      in_cluster = '0;
      in_roll    = '0;
      in_pad     = '0;
      in_size    = '0;
      repeat (3) @(posedge logic_clock);
      #2;
      rst_n = 1'b1;
      repeat (N_BASIC) send_random(1'b0);    // back to back at the default config
      send_corners();
      write_cfg(OP_SET_PARITY, 8'h00);       // odd tables
      repeat (N_BASIC) send_random(1'b0);
      send_corners();
      for (int i = 0; i < N_WIN; i++) begin
         write_cfg(OP_SET_HS_WINDOW, 8'($urandom_range(31)));
         write_cfg(OP_SET_WG_WINDOW, 8'($urandom_range(7)));
         write_cfg(OP_SET_PARITY, 8'($urandom_range(1)));
         repeat (N_RUN) send_random(1'b0);
         send_corners();
      end
      for (int en = 0; en < 8; en++) begin
         write_cfg(OP_SET_ENABLES, 8'(en));
         repeat (N_RUN) send_random(1'b0);
      end
      write_cfg(OP_SET_ENABLES, 8'h07);
      write_cfg(OP_SET_PARITY, 8'h01);
      repeat (4) send_random(1'b1);
      write_cfg(OP_SET_PARITY, 8'h01);       // repeated parity needs no flush
      repeat (4) send_random(1'b1);
      write_cfg(OP_SET_PARITY, 8'h00);
      repeat (3) send_random(1'b1);
      repeat (DRAIN) send(1'b0, 0, 0, 0);
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// File: files.f
src/gem_csc_pkg.sv
src/gem_csc_cfg_pkg.sv
src/gem_csc_ifs.sv
src/gem_pad_xky_lut.sv
src/gem_roll_wg_lut.sv
src/cluster_match_ctrl.sv
src/cluster_window_calc.sv
src/cluster_to_csc_top.sv
verification/cluster_to_csc_assert.sv
verification/tb_cluster_to_csc.sv

// File: Bender.yml
package:
  name: cluster_to_csc

sources:
  - src/gem_csc_pkg.sv
  - src/gem_csc_cfg_pkg.sv
  - src/gem_csc_ifs.sv
  - src/gem_pad_xky_lut.sv
  - src/gem_roll_wg_lut.sv
  - src/cluster_match_ctrl.sv
  - src/cluster_window_calc.sv
  - src/cluster_to_csc_top.sv
  - target: simulation
    files:
      - verification/cluster_to_csc_assert.sv
      - verification/tb_cluster_to_csc.sv
